// File: filelist.f
+incdir+source
source/safe_bus_pkg.sv
source/mode_ctrl.sv
source/tmr_voter.sv
source/dmr_comparator.sv
source/bus_isolator.sv
source/redundant_channel.sv
source/safe_bus_top.sv
testbench/tb_safe_bus.sv

// File: run.sh
#!/usr/bin/env bash
# Compiles the testbench with Verilator and runs it.
# The exit status is nonzero unless the simulation output holds the pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f filelist.f --top-module tb_safe_bus \
  -Mdir obj_dir -o sim_tb_safe_bus &&
./obj_dir/sim_tb_safe_bus | tee /dev/stderr | grep -qx "TESTBENCH PASSED" &&
echo "Simulation run succeeded" ||
{ echo "Simulation run failed" >&2; exit 1; }

// File: testbench/tb_safe_bus.sv
/*
  Self-checking testbench for the safe bus wrapper.
  Walks a table of configurations and bus traffic, then checks routing and error flags.
*/
`timescale 1ns/1ps
`default_nettype none
`include "safe_bus_consts.svh"

module tb_safe_bus;
  import safe_bus_pkg::*;

  // One table row holds stimulus first and expected values after
  typedef struct packed {
    hart_vec_t                 sleep;
    safe_mode_e                mode;
    hart_vec_t                 master;
    hart_vec_t                 mask;
    logic                      clr;
    obi_req_t [`SB_NHARTS-1:0] core_req;
    obi_rsp_t [`SB_NHARTS-1:0] mem_rsp;
    obi_req_t [`SB_NHARTS-1:0] exp_mem_req;
    obi_rsp_t [`SB_NHARTS-1:0] exp_core_rsp;
    hart_vec_t                 exp_iso;
    logic                      exp_tmr_err;
    logic                      exp_dmr_err;
    hart_vec_t                 exp_err_id;
  } test_row_t;

  typedef struct packed {
    logic      tmr;
    logic      dmr;
    hart_vec_t id;
  } err_flags_t;

  logic                      clk;
  logic                      rst_n;
  obi_req_t [`SB_NHARTS-1:0] core_instr_req;
  obi_req_t [`SB_NHARTS-1:0] core_data_req;
  obi_rsp_t [`SB_NHARTS-1:0] core_instr_rsp;
  obi_rsp_t [`SB_NHARTS-1:0] core_data_rsp;
  obi_req_t [`SB_NHARTS-1:0] mem_instr_req;
  obi_req_t [`SB_NHARTS-1:0] mem_data_req;
  obi_rsp_t [`SB_NHARTS-1:0] mem_instr_rsp;
  obi_rsp_t [`SB_NHARTS-1:0] mem_data_rsp;
  safe_mode_e                mode;
  hart_vec_t                 master;
  hart_vec_t                 dmr_mask;
  hart_vec_t                 sleep;
  logic                      err_clear;
  logic                      tmr_error;
  logic                      dmr_error;
  hart_vec_t                 tmr_error_id;

  int        errors;
  test_row_t rows[$];
  string     row_names[$];

  safe_bus_top DUT (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .core_instr_req_i (core_instr_req),
    .core_data_req_i  (core_data_req),
    .core_instr_rsp_o (core_instr_rsp),
    .core_data_rsp_o  (core_data_rsp),
    .mem_instr_req_o  (mem_instr_req),
    .mem_data_req_o   (mem_data_req),
    .mem_instr_rsp_i  (mem_instr_rsp),
    .mem_data_rsp_i   (mem_data_rsp),
    .mode_i           (mode),
    .master_i         (master),
    .dmr_mask_i       (dmr_mask),
    .sleep_i          (sleep),
    .err_clear_i      (err_clear),
    .tmr_error_o      (tmr_error),
    .dmr_error_o      (dmr_error),
    .tmr_error_id_o   (tmr_error_id)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic obi_req_t rand_req();
    obi_req_t    r;
    logic [31:0] word;
    word    = $urandom;
    r.req   = 1'b1;
    r.we    = word[4];
    r.be    = word[3:0];
    r.addr  = $urandom & 32'hffff_fffc;
    r.wdata = $urandom;
    return r;
  endfunction

  // Memory answer with random back-pressure and rvalid
  function automatic obi_rsp_t rand_rsp();
    obi_rsp_t    r;
    logic [31:0] word;
    word     = $urandom;
    r.gnt    = word[0];
    r.rvalid = word[1];
    r.rdata  = $urandom;
    return r;
  endfunction

  // Isolated fetch is granted in its request cycle and not yet answered
  function automatic obi_rsp_t iso_fetch_rsp(input obi_req_t req);
    obi_rsp_t r;
    r.gnt    = req.req;
    r.rvalid = 1'b0;
    r.rdata  = `SB_WFI_INSTR;
    return r;
  endfunction

  task automatic check_req(input string name, input string what, input int h,
                           input obi_req_t exp, input obi_req_t act);
    if (act !== exp) begin
      errors++;
      $display("Fail %s %s[%0d]: expected %h, actual %h", name, what, h, exp, act);
    end
  endtask

  task automatic check_rsp(input string name, input string what, input int h,
                           input obi_rsp_t exp, input obi_rsp_t act);
    if (act !== exp) begin
      errors++;
      $display("Fail %s %s[%0d]: expected %h, actual %h", name, what, h, exp, act);
    end
  endtask

  task automatic add_row(input string name, input test_row_t row);
    row_names.push_back(name);
    rows.push_back(row);
  endtask

  task automatic build_table();
    test_row_t r;
    obi_req_t  a;
    obi_req_t  b;
    obi_req_t  c;
    obi_req_t  idle;
    obi_rsp_t  x0;
    obi_rsp_t  x1;
    obi_rsp_t  x2;
    idle = '0;
    a = rand_req();
    // Corrupted copy and an unrelated access
    b = a;
    b.wdata = ~a.wdata;
    c = rand_req();
    c.addr = a.addr + 32'd4;
    x0 = rand_rsp();
    x1 = rand_rsp();
    x2 = rand_rsp();

    r = '0;
    r.master = 3'b001;
    r.mask = 3'b011;
    r.core_req = {c, b, a};
    r.mem_rsp = {x2, x1, x0};
    r.exp_mem_req = {c, b, a};
    r.exp_core_rsp = {x2, x1, x0};
    add_row("reset_single", r);

    r.sleep = 3'b111;
    r.mode = MODE_TMR;
    r.master = 3'b010;
    r.core_req = {a, a, a};
    r.exp_mem_req = {idle, a, idle};
    r.exp_core_rsp = {x1, x1, x1};
    add_row("tmr_equal", r);
    // Hart 0 is outvoted by harts 1 and 2
    r.core_req = {a, a, b};
    r.exp_tmr_err = 1'b1;
    r.exp_err_id = 3'b001;
    add_row("tmr_corrupt", r);
    r.core_req = {a, a, a};
    add_row("tmr_sticky", r);
    r.clr = 1'b1;
    r.exp_tmr_err = 1'b0;
    r.exp_err_id = 3'b000;
    add_row("tmr_clear", r);

    // Pair is harts 0 and 2 so hart 1 is left out
    r.clr = 1'b0;
    r.mode = MODE_DMR;
    r.master = 3'b001;
    r.mask = 3'b101;
    r.core_req = {a, c, a};
    r.exp_mem_req = {idle, idle, a};
    r.exp_core_rsp = {x0, iso_fetch_rsp(c), x0};
    r.exp_iso = 3'b010;
    add_row("dmr_equal", r);
    r.core_req = {b, c, a};
    r.exp_dmr_err = 1'b1;
    add_row("dmr_diff", r);

    // DMR routing stays since not all harts are asleep
    r.sleep = 3'b011;
    r.mode = MODE_SINGLE;
    r.mask = 3'b011;
    r.clr = 1'b1;
    r.core_req = {a, c, a};
    r.exp_dmr_err = 1'b0;
    add_row("no_latch", r);

    r.sleep = 3'b111;
    r.clr = 1'b0;
    r.core_req = {c, b, a};
    r.exp_mem_req = {c, b, a};
    r.exp_core_rsp = {x2, x1, x0};
    r.exp_iso = 3'b000;
    add_row("back_to_single", r);
  endtask

  task automatic apply_row(input string name, input test_row_t row);
    obi_rsp_t [`SB_NHARTS-1:0] drain;
    obi_rsp_t [`SB_NHARTS-1:0] exp_data_rsp;
    obi_rsp_t                  late;
    err_flags_t                exp_flags;
    err_flags_t                act_flags;
    drain = '0;
    exp_data_rsp = row.exp_core_rsp;
    for (int h = 0; h < `SB_NHARTS; h++) begin
      drain[h].rvalid = 1'b1;
      if (row.exp_iso[h]) begin
        exp_data_rsp[h].rdata = '0;
      end
    end

    // Latch cycle with idle harts and outstanding responses answered
    @(negedge clk);
    sleep = row.sleep;
    mode = row.mode;
    master = row.master;
    dmr_mask = row.mask;
    err_clear = row.clr;
    core_instr_req = '0;
    core_data_req = '0;
    mem_instr_rsp = drain;
    mem_data_rsp = drain;

    @(negedge clk);
    sleep = '0;
    err_clear = 1'b0;
    core_instr_req = row.core_req;
    core_data_req = row.core_req;
    mem_instr_rsp = row.mem_rsp;
    mem_data_rsp = row.mem_rsp;
    #2;
    for (int h = 0; h < `SB_NHARTS; h++) begin
      check_req(name, "instr mem req", h, row.exp_mem_req[h], mem_instr_req[h]);
      check_req(name, "data mem req", h, row.exp_mem_req[h], mem_data_req[h]);
      check_rsp(name, "instr core rsp", h, row.exp_core_rsp[h], core_instr_rsp[h]);
      check_rsp(name, "data core rsp", h, exp_data_rsp[h], core_data_rsp[h]);
    end

    @(posedge clk);
    #1;
    exp_flags = {row.exp_tmr_err, row.exp_dmr_err, row.exp_err_id};
    act_flags = {tmr_error, dmr_error, tmr_error_id};
    if (act_flags !== exp_flags) begin
      errors++;
      $display("Fail %s error flags: expected %b, actual %b", name, exp_flags, act_flags);
    end
    // Isolated harts get their rvalid one cycle after the grant
    for (int h = 0; h < `SB_NHARTS; h++) begin
      if (row.exp_iso[h] && row.core_req[h].req) begin
        late.gnt = 1'b1;
        late.rvalid = 1'b1;
        late.rdata = `SB_WFI_INSTR;
        check_rsp(name, "instr iso rvalid", h, late, core_instr_rsp[h]);
        late.rdata = '0;
        check_rsp(name, "data iso rvalid", h, late, core_data_rsp[h]);
      end
    end
  endtask

  initial begin
    int seed_ret;
    int wait_cycles;
    seed_ret = $urandom(32'h9a50_813c);
    errors = 0;
    rst_n = 1'b0;
    core_instr_req = '0;
    core_data_req = '0;
    mem_instr_rsp = '0;
    mem_data_rsp = '0;
    mode = MODE_SINGLE;
    master = 3'b001;
    dmr_mask = 3'b011;
    sleep = '0;
    err_clear = 1'b0;
    build_table();

    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    wait_cycles = 0;
    while ((tmr_error !== 1'b0 || dmr_error !== 1'b0) && wait_cycles < 4) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (tmr_error !== 1'b0 || dmr_error !== 1'b0) begin
      $display("Error flags still not low 4 cycles after reset release");
      $display("TESTBENCH FAILED");
      $finish;
    end

    foreach (rows[i]) begin
      apply_row(row_names[i], rows[i]);
    end

    $display("Rows applied: %0d, errors: %0d", rows.size(), errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/safe_bus_top.sv
/*
  Safe bus wrapper top.
  Joins the configuration block with the instruction and data channels.
*/
`timescale 1ns/1ps
`default_nettype none
`include "safe_bus_consts.svh"

module safe_bus_top (
  input  wire                                     clk_i,
  input  wire                                     rst_ni,
  input  safe_bus_pkg::obi_req_t [`SB_NHARTS-1:0] core_instr_req_i,
  input  safe_bus_pkg::obi_req_t [`SB_NHARTS-1:0] core_data_req_i,
  output safe_bus_pkg::obi_rsp_t [`SB_NHARTS-1:0] core_instr_rsp_o,
  output safe_bus_pkg::obi_rsp_t [`SB_NHARTS-1:0] core_data_rsp_o,
  output safe_bus_pkg::obi_req_t [`SB_NHARTS-1:0] mem_instr_req_o,
  output safe_bus_pkg::obi_req_t [`SB_NHARTS-1:0] mem_data_req_o,
  input  safe_bus_pkg::obi_rsp_t [`SB_NHARTS-1:0] mem_instr_rsp_i,
  input  safe_bus_pkg::obi_rsp_t [`SB_NHARTS-1:0] mem_data_rsp_i,
  input  safe_bus_pkg::safe_mode_e                mode_i,
  input  safe_bus_pkg::hart_vec_t                 master_i,
  input  safe_bus_pkg::hart_vec_t                 dmr_mask_i,
  input  safe_bus_pkg::hart_vec_t                 sleep_i,
  input  logic                                    err_clear_i,
  output logic                                    tmr_error_o,
  output logic                                    dmr_error_o,
  output safe_bus_pkg::hart_vec_t                 tmr_error_id_o
);
  import safe_bus_pkg::*;

  // Index 0 is the instruction channel, 1 the data channel
  redundancy_cfg_t  cfg;
  logic [1:0]       tmr_mismatch;
  logic [1:0]       dmr_mismatch;
  hart_vec_t [1:0]  tmr_dissent;

  mode_ctrl u_mode_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .mode_i         (mode_i),
    .master_i       (master_i),
    .dmr_mask_i     (dmr_mask_i),
    .sleep_i        (sleep_i),
    .tmr_mismatch_i (tmr_mismatch),
    .dmr_mismatch_i (dmr_mismatch),
    .tmr_dissent_i  (tmr_dissent),
    .err_clear_i    (err_clear_i),
    .cfg_o          (cfg),
    .tmr_error_o    (tmr_error_o),
    .dmr_error_o    (dmr_error_o),
    .tmr_error_id_o (tmr_error_id_o)
  );

  // Isolated fetches see WFI so the hart parks itself
  redundant_channel #(
    .ISO_RDATA (`SB_WFI_INSTR)
  ) u_instr_ch (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cfg_i          (cfg),
    .core_req_i     (core_instr_req_i),
    .core_rsp_o     (core_instr_rsp_o),
    .mem_req_o      (mem_instr_req_o),
    .mem_rsp_i      (mem_instr_rsp_i),
    .tmr_mismatch_o (tmr_mismatch[0]),
    .dmr_mismatch_o (dmr_mismatch[0]),
    .tmr_dissent_o  (tmr_dissent[0])
  );

  redundant_channel #(
    .ISO_RDATA ('0)
  ) u_data_ch (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cfg_i          (cfg),
    .core_req_i     (core_data_req_i),
    .core_rsp_o     (core_data_rsp_o),
    .mem_req_o      (mem_data_req_o),
    .mem_rsp_i      (mem_data_rsp_i),
    .tmr_mismatch_o (tmr_mismatch[1]),
    .dmr_mismatch_o (dmr_mismatch[1]),
    .tmr_dissent_o  (tmr_dissent[1])
  );

endmodule

`default_nettype wire

// File: source/redundant_channel.sv
/*
  Request and response steering for one bus between three harts and three ports.
  Used twice, once for instruction fetches and once for data accesses.
*/
`timescale 1ns/1ps
`default_nettype none
`include "safe_bus_consts.svh"

module redundant_channel #(
  parameter safe_bus_pkg::data_t ISO_RDATA = '0
) (
  input  wire                                     clk_i,
  input  wire                                     rst_ni,
  input  safe_bus_pkg::redundancy_cfg_t           cfg_i,
  input  safe_bus_pkg::obi_req_t [`SB_NHARTS-1:0] core_req_i,
  output safe_bus_pkg::obi_rsp_t [`SB_NHARTS-1:0] core_rsp_o,
  output safe_bus_pkg::obi_req_t [`SB_NHARTS-1:0] mem_req_o,
  input  safe_bus_pkg::obi_rsp_t [`SB_NHARTS-1:0] mem_rsp_i,
  output logic                                    tmr_mismatch_o,
  output logic                                    dmr_mismatch_o,
  output safe_bus_pkg::hart_vec_t                 tmr_dissent_o
);
  import safe_bus_pkg::*;

  obi_req_t                  voted_req;
  obi_req_t                  compared_req;
  obi_rsp_t                  master_rsp;
  obi_rsp_t [`SB_NHARTS-1:0] live_rsp;
  obi_rsp_t [`SB_NHARTS-1:0] iso_rsp;
  logic                      redundant;

  assign redundant = cfg_i.tmr_en | cfg_i.dmr_en;

  tmr_voter u_voter (
    .req_i      (core_req_i),
    .voted_o    (voted_req),
    .mismatch_o (tmr_mismatch_o),
    .dissent_o  (tmr_dissent_o)
  );

  // Pair is everyone not isolated
  dmr_comparator u_comparator (
    .req_i      (core_req_i),
    .master_i   (cfg_i.master),
    .pair_i     (~cfg_i.isolate),
    .compared_o (compared_req),
    .mismatch_o (dmr_mismatch_o)
  );

  // Only the master port talks to memory in the redundant modes
  always_comb begin
    for (int p = 0; p < `SB_NHARTS; p++) begin
      if (cfg_i.tmr_en) begin
        mem_req_o[p] = cfg_i.master[p] ? voted_req : '0;
      end else if (cfg_i.dmr_en) begin
        mem_req_o[p] = cfg_i.master[p] ? compared_req : '0;
      end else begin
        mem_req_o[p] = core_req_i[p];
      end
    end
  end

  always_comb begin
    master_rsp = '0;
    for (int p = 0; p < `SB_NHARTS; p++) begin
      if (cfg_i.master[p]) begin
        master_rsp = mem_rsp_i[p];
      end
    end
  end

  for (genvar h = 0; h < `SB_NHARTS; h++) begin : gen_hart
    // What the hart sees while still attached to memory
    assign live_rsp[h] = redundant ? master_rsp : mem_rsp_i[h];

    bus_isolator #(
      .RDATA (ISO_RDATA)
    ) u_isolator (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .isolate_i  (cfg_i.isolate[h]),
      .req_i      (core_req_i[h]),
      .live_rsp_i (live_rsp[h]),
      .rsp_o      (iso_rsp[h])
    );

    assign core_rsp_o[h] = cfg_i.isolate[h] ? iso_rsp[h] : live_rsp[h];
  end

endmodule

`default_nettype wire

// File: source/bus_isolator.sv
/*
  Stand-in memory responder for one hart cut off from its bus.
  Grants at once and answers one cycle later with a fixed word.
*/
`timescale 1ns/1ps
`default_nettype none

module bus_isolator #(
  parameter safe_bus_pkg::data_t RDATA = '0
) (
  input  wire                    clk_i,
  input  wire                    rst_ni,
  input  logic                   isolate_i,
  input  safe_bus_pkg::obi_req_t req_i,
  input  safe_bus_pkg::obi_rsp_t live_rsp_i,
  output safe_bus_pkg::obi_rsp_t rsp_o
);

  logic pending_q;
  logic iso_rvalid_q;
  logic live_grant;

  assign live_grant = req_i.req & live_rsp_i.gnt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q    <= 1'b0;
      iso_rvalid_q <= 1'b0;
    end else if (!isolate_i) begin
      // Remember a granted request still waiting for memory
      pending_q    <= live_grant | (pending_q & ~live_rsp_i.rvalid);
      iso_rvalid_q <= 1'b0;
    end else begin
      pending_q    <= 1'b0;
      iso_rvalid_q <= req_i.req;
    end
  end

  // Owed response lands in the first isolated cycle
  assign rsp_o.gnt    = req_i.req;
  assign rsp_o.rvalid = iso_rvalid_q | pending_q;
  assign rsp_o.rdata  = RDATA;

endmodule

`default_nettype wire

// File: source/dmr_comparator.sv
/*
  Lockstep compare for one bus.
  Forwards the master's request and flags any difference to its pair partner.
*/
`timescale 1ns/1ps
`default_nettype none
`include "safe_bus_consts.svh"

module dmr_comparator (
  input  safe_bus_pkg::obi_req_t [`SB_NHARTS-1:0] req_i,
  input  safe_bus_pkg::hart_vec_t                 master_i,
  input  safe_bus_pkg::hart_vec_t                 pair_i,
  output safe_bus_pkg::obi_req_t                  compared_o,
  output logic                                    mismatch_o
);
  import safe_bus_pkg::*;

  hart_vec_t partner;
  obi_req_t  master_req;
  obi_req_t  partner_req;

  // The pair member that is not the master
  assign partner = pair_i & ~master_i;

  always_comb begin
    master_req  = '0;
    partner_req = '0;
    for (int i = 0; i < `SB_NHARTS; i++) begin
      if (master_i[i]) begin
        master_req = req_i[i];
      end
      if (partner[i]) begin
        partner_req = req_i[i];
      end
    end
  end

  assign compared_o = master_req;
  assign mismatch_o = (master_req != partner_req);

endmodule

`default_nettype wire

// File: source/tmr_voter.sv
/*
  Majority vote over the three hart requests of one bus.
  Purely combinational, flags any disagreement and names the odd hart out.
*/
`timescale 1ns/1ps
`default_nettype none
`include "safe_bus_consts.svh"

module tmr_voter (
  input  safe_bus_pkg::obi_req_t [`SB_NHARTS-1:0] req_i,
  output safe_bus_pkg::obi_req_t                  voted_o,
  output logic                                    mismatch_o,
  output safe_bus_pkg::hart_vec_t                 dissent_o
);
  import safe_bus_pkg::*;

  logic      eq01;
  logic      eq02;
  logic      eq12;
  obi_req_t  voted;
  hart_vec_t dissent;

  // Whole-struct compare, so idle fields count too
  assign eq01 = (req_i[0] == req_i[1]);
  assign eq02 = (req_i[0] == req_i[2]);
  assign eq12 = (req_i[1] == req_i[2]);

  always_comb begin
    if (eq01 || eq02) begin
      voted = req_i[0];
    end else if (eq12) begin
      voted = req_i[1];
    end else begin
      // No majority, fall back to hart 0
      voted = req_i[0];
    end
  end

  always_comb begin
    if (eq01 && eq12) begin
      dissent = '0;
    end else if (eq01) begin
      dissent = 3'b100;
    end else if (eq02) begin
      dissent = 3'b010;
    end else if (eq12) begin
      dissent = 3'b001;
    end else begin
      dissent = '1;
    end
  end

  assign voted_o    = voted;
  assign mismatch_o = !(eq01 && eq12);
  assign dissent_o  = dissent;

endmodule

`default_nettype wire

// File: source/mode_ctrl.sv
/*
  Redundancy configuration register and sticky error flags.
  Mode, master and pair mask are taken only while every hart sleeps.
*/
`timescale 1ns/1ps
`default_nettype none
`include "safe_bus_consts.svh"

module mode_ctrl (
  input  wire                                clk_i,
  input  wire                                rst_ni,
  input  safe_bus_pkg::safe_mode_e           mode_i,
  input  safe_bus_pkg::hart_vec_t            master_i,
  input  safe_bus_pkg::hart_vec_t            dmr_mask_i,
  input  safe_bus_pkg::hart_vec_t            sleep_i,
  input  logic [1:0]                         tmr_mismatch_i,
  input  logic [1:0]                         dmr_mismatch_i,
  input  safe_bus_pkg::hart_vec_t [1:0]      tmr_dissent_i,
  input  logic                               err_clear_i,
  output safe_bus_pkg::redundancy_cfg_t      cfg_o,
  output logic                               tmr_error_o,
  output logic                               dmr_error_o,
  output safe_bus_pkg::hart_vec_t            tmr_error_id_o
);
  import safe_bus_pkg::*;

  // Single mode, hart 0 as master, nobody isolated
  localparam redundancy_cfg_t cfg_reset = '{
    tmr_en:  1'b0,
    dmr_en:  1'b0,
    master:  hart_vec_t'(1),
    isolate: '0
  };

  redundancy_cfg_t cfg_d;
  redundancy_cfg_t cfg_q;
  logic            tmr_hit;
  logic            dmr_hit;
  hart_vec_t       id_hit;
  logic            tmr_error_q;
  logic            dmr_error_q;
  hart_vec_t       tmr_id_q;

  always_comb begin
    cfg_d.tmr_en  = (mode_i == MODE_TMR);
    cfg_d.dmr_en  = (mode_i == MODE_DMR);
    cfg_d.master  = master_i;
    // The hart outside the lockstep pair gets isolated
    cfg_d.isolate = (mode_i == MODE_DMR) ? ~dmr_mask_i : '0;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q <= cfg_reset;
    end else if (&sleep_i) begin
      cfg_q <= cfg_d;
    end
  end

  // Either channel counts, but only in the matching latched mode
  assign tmr_hit = cfg_q.tmr_en & (|tmr_mismatch_i);
  assign dmr_hit = cfg_q.dmr_en & (|dmr_mismatch_i);
  assign id_hit  = cfg_q.tmr_en ? (tmr_dissent_i[0] | tmr_dissent_i[1]) : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tmr_error_q <= 1'b0;
      dmr_error_q <= 1'b0;
      tmr_id_q    <= '0;
    end else if (err_clear_i) begin
      tmr_error_q <= 1'b0;
      dmr_error_q <= 1'b0;
      tmr_id_q    <= '0;
    end else begin
      tmr_error_q <= tmr_error_q | tmr_hit;
      dmr_error_q <= dmr_error_q | dmr_hit;
      tmr_id_q    <= tmr_id_q | id_hit;
    end
  end

  assign cfg_o          = cfg_q;
  assign tmr_error_o    = tmr_error_q;
  assign dmr_error_o    = dmr_error_q;
  assign tmr_error_id_o = tmr_id_q;

  master_onehot_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot(cfg_q.master));

  // Pair of two, with the master inside it
  dmr_pair_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    cfg_q.dmr_en |-> $onehot(cfg_q.isolate) && !(|(cfg_q.master & cfg_q.isolate)));

endmodule

`default_nettype wire

// File: source/safe_bus_pkg.sv
/*
  Bus and configuration types for the safe bus wrapper.
  Modules import it inside their body and name its types scoped in their ports.
*/
`default_nettype none
`include "safe_bus_consts.svh"

package safe_bus_pkg;

  typedef logic [`SB_ADDR_W-1:0]   addr_t;
  typedef logic [`SB_DATA_W-1:0]   data_t;
  typedef logic [`SB_DATA_W/8-1:0] be_t;
  typedef logic [`SB_NHARTS-1:0]   hart_vec_t;

  typedef struct packed {
    logic  req;
    logic  we;
    be_t   be;
    addr_t addr;
    data_t wdata;
  } obi_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    data_t rdata;
  } obi_rsp_t;

  typedef enum logic [1:0] {
    MODE_SINGLE = 2'd0,
    MODE_TMR    = 2'd1,
    MODE_DMR    = 2'd2
  } safe_mode_e;

  // Latched redundancy setup, one-hot master and isolated hart
  typedef struct packed {
    logic      tmr_en;
    logic      dmr_en;
    hart_vec_t master;
    hart_vec_t isolate;
  } redundancy_cfg_t;

endpackage

`default_nettype wire

// File: source/safe_bus_consts.svh
/*
  Sizes and fixed codes shared by the safe bus wrapper.
  Included by the package and by modules that size per-hart arrays.
*/
`ifndef SAFE_BUS_CONSTS_SVH
`define SAFE_BUS_CONSTS_SVH

// Harts behind the wrapper
`define SB_NHARTS 3

// OBI bus widths
`define SB_ADDR_W 32
`define SB_DATA_W 32

// Returned as every fetch to an isolated hart
`define SB_WFI_INSTR 32'h10500073

`endif
